// File: hw/img_pkg.sv
package img_pkg;

    // --------------------
    // image geometry
    localparam int IMG_W   = 8;
    localparam int IMG_H   = 8;
    localparam int IMG_C   = 32;
    localparam int IMG_PIX = IMG_W * IMG_H * IMG_C;    // 2048 pixels

    localparam int BANK_COUNT = 4;
    localparam int BANK_AW    = 9;                     // 512 words per bank
    localparam int OUT_W      = 14;

    typedef enum logic [3:0] {
        LOAD    = 4'd0,
        ORG_R   = 4'd1,
        ORG_L   = 4'd2,
        ORG_U   = 4'd3,
        ORG_D   = 4'd4,
        SCALE_D = 4'd5,
        SCALE_U = 4'd6,
        DISPLAY = 4'd7
    } op_e;

    typedef enum logic [1:0] {
        D8  = 2'd0,
        D16 = 2'd1,
        D32 = 2'd2
    } depth_e;

    function automatic logic [4:0] last_channel(depth_e depth);
        case (depth)
            D8:      return 5'd7;
            D16:     return 5'd15;
            default: return 5'd31;
        endcase
    endfunction

    // one address word with two decodings
    typedef union packed {
        struct packed {
            logic [1:0] bank;
            logic [8:0] word;
        } bnk;                  // seen by the banks
        struct packed {
            logic [1:0] bank;   // channel low bits
            logic [2:0] ch_hi;
            logic [2:0] row;
            logic [2:0] col;
        } pix;                  // filled by the address generators
    } pix_addr_u;

endpackage

// File: hw/buf_read_if.sv
interface buf_read_if;
    import img_pkg::*;

    logic       rd_en;
    pix_addr_u  rd_addr;
    logic [7:0] rd_data;
    logic       rd_valid;   // one cycle behind rd_en

    // display streamer side
    modport requester (
        output rd_en,
        output rd_addr,
        input  rd_data,
        input  rd_valid
    );

    // image buffer side
    modport memory (
        input  rd_en,
        input  rd_addr,
        output rd_data,
        output rd_valid
    );

endinterface

// File: hw/sram_bank.sv
module sram_bank #(
    parameter int BANK_AW = img_pkg::BANK_AW
) (
    input  logic               i_clk,
    input  logic               i_en,
    input  logic               i_we,
    input  logic [BANK_AW-1:0] i_addr,
    input  logic [7:0]         i_d,
    output logic [7:0]         o_q
);

    localparam int DEPTH = 2 ** BANK_AW;

    logic [7:0] mem [DEPTH];

    // single port, write has priority over read
    always_ff @(posedge i_clk) begin
        if (i_en) begin
            if (i_we) begin
                mem[i_addr] <= i_d;
            end else begin
                o_q <= mem[i_addr];     // holds until the next read
            end
        end
    end

endmodule

// File: hw/image_buffer.sv
module image_buffer #(
    parameter int BANK_AW = img_pkg::BANK_AW
) (
    input  logic               i_clk,
    input  logic               i_wr_en,
    input  img_pkg::pix_addr_u i_wr_addr,
    input  logic [7:0]         i_wr_data,
    buf_read_if.memory         rd
);
    import img_pkg::*;

    logic [BANK_AW-1:0] wr_word;
    logic [BANK_AW-1:0] rd_word;
    logic [7:0]         bank_q [BANK_COUNT];
    logic [1:0]         rd_bank_q;              // bank of the read in flight

    // upper words stay unused when banks are larger
    assign wr_word = BANK_AW'(i_wr_addr.bnk.word);
    assign rd_word = BANK_AW'(rd.rd_addr.bnk.word);

    // --------------------
    // bank array
    for (genvar gi = 0; gi < BANK_COUNT; gi++) begin : g_bank
        logic wr_hit;
        logic rd_hit;

        assign wr_hit = i_wr_en && (i_wr_addr.bnk.bank == 2'(gi));
        assign rd_hit = rd.rd_en && (rd.rd_addr.bnk.bank == 2'(gi));

        sram_bank #(
            .BANK_AW (BANK_AW)
        ) sram_bank_i (
            .i_clk  (i_clk),
            .i_en   (wr_hit || rd_hit),
            .i_we   (wr_hit),
            .i_addr (wr_hit ? wr_word : rd_word),
            .i_d    (i_wr_data),
            .o_q    (bank_q[gi])
        );
    end

    // --------------------
    // read return path
    always_ff @(posedge i_clk) begin
        if (rd.rd_en) begin
            rd_bank_q <= rd.rd_addr.bnk.bank;
        end
        rd.rd_valid <= rd.rd_en;
    end

    assign rd.rd_data = bank_q[rd_bank_q];

    // load and display never collide on one bank
    assert property (@(posedge i_clk)
        !(i_wr_en && rd.rd_en && (i_wr_addr.bnk.bank == rd.rd_addr.bnk.bank)));

endmodule

// File: hw/op_control.sv
module op_control (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_op_valid,
    input  logic [3:0]         i_op_mode,
    input  logic               i_in_valid,
    input  logic [7:0]         i_in_data,
    input  logic               i_disp_done,
    output logic               o_op_ready,
    output logic               o_in_ready,
    output logic               o_wr_en,
    output img_pkg::pix_addr_u o_wr_addr,
    output logic [7:0]         o_wr_data,
    output logic               o_disp_start,
    output logic [2:0]         o_origin_x,
    output logic [2:0]         o_origin_y,
    output img_pkg::depth_e    o_depth
);
    import img_pkg::*;

    localparam logic [2:0] ST_RESET  = 3'd0;
    localparam logic [2:0] ST_IDLE   = 3'd1;
    localparam logic [2:0] ST_LOAD   = 3'd2;
    localparam logic [2:0] ST_ADJUST = 3'd3;
    localparam logic [2:0] ST_DISP   = 3'd4;   // waiting on the streamer
    localparam logic [2:0] ST_READY  = 3'd5;

    logic [2:0]  state;
    logic [2:0]  state_next;
    op_e         op_q;          // op held for the adjust cycle
    logic [10:0] load_cnt;      // raster position, channel-major
    logic        op_take;
    logic        pix_take;
    logic        load_last;

    assign op_take   = (state == ST_IDLE) && i_op_valid;
    assign pix_take  = o_in_ready && i_in_valid;
    assign load_last = pix_take && (load_cnt == 11'(IMG_PIX - 1));

    // --------------------
    // command FSM
    always_comb begin
        state_next = state;
        case (state)
            ST_RESET: state_next = ST_READY;
            ST_READY: state_next = ST_IDLE;
            ST_IDLE: begin
                if (i_op_valid) begin
                    case (op_e'(i_op_mode))
                        LOAD:    state_next = ST_LOAD;
                        DISPLAY: state_next = ST_DISP;
                        default: state_next = ST_ADJUST;   // shifts, scales, unknown
                    endcase
                end
            end
            ST_LOAD: begin
                if (load_last) begin
                    state_next = ST_READY;
                end
            end
            ST_ADJUST: state_next = ST_READY;
            ST_DISP: begin
                if (i_disp_done) begin
                    state_next = ST_READY;
                end
            end
            default: state_next = ST_RESET;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state        <= ST_RESET;
            op_q         <= LOAD;
            load_cnt     <= '0;
            o_disp_start <= 1'b0;
            o_origin_x   <= 3'd0;
            o_origin_y   <= 3'd0;
            o_depth      <= D32;
        end else begin
            state        <= state_next;
            o_disp_start <= op_take && (op_e'(i_op_mode) == DISPLAY);
            if (op_take) begin
                op_q <= op_e'(i_op_mode);
            end
            if (pix_take) begin
                load_cnt <= load_cnt + 11'd1;   // wraps to 0 after the last pixel
            end
            // window origin stays within 0..6, depth within 8..32
            if (state == ST_ADJUST) begin
                case (op_q)
                    ORG_R:   if (o_origin_x < 3'd6) o_origin_x <= o_origin_x + 3'd1;
                    ORG_L:   if (o_origin_x > 3'd0) o_origin_x <= o_origin_x - 3'd1;
                    ORG_U:   if (o_origin_y > 3'd0) o_origin_y <= o_origin_y - 3'd1;
                    ORG_D:   if (o_origin_y < 3'd6) o_origin_y <= o_origin_y + 3'd1;
                    SCALE_D: if (o_depth != D8)  o_depth <= depth_e'(o_depth - 2'd1);
                    SCALE_U: if (o_depth != D32) o_depth <= depth_e'(o_depth + 2'd1);
                    default: ;  // undefined opcodes leave everything as is
                endcase
            end
        end
    end

    // --------------------
    // handshake and write port
    assign o_op_ready = (state == ST_READY);
    assign o_in_ready = (state == ST_LOAD);
    assign o_wr_en    = pix_take;
    assign o_wr_data  = i_in_data;

    always_comb begin
        o_wr_addr.pix.bank  = load_cnt[7:6];    // channel low bits pick the bank
        o_wr_addr.pix.ch_hi = load_cnt[10:8];
        o_wr_addr.pix.row   = load_cnt[5:3];
        o_wr_addr.pix.col   = load_cnt[2:0];
    end

    // done only arrives while a display is running
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_disp_done |-> (state == ST_DISP));

    // each load starts from the first pixel
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (op_take && (op_e'(i_op_mode) == LOAD)) |-> (load_cnt == '0));

endmodule

// File: hw/display_streamer.sv
module display_streamer (
    input  logic                             i_clk,
    input  logic                             i_rst_n,
    input  logic                             i_start,
    input  logic [2:0]                       i_origin_x,
    input  logic [2:0]                       i_origin_y,
    input  img_pkg::depth_e                  i_depth,
    buf_read_if.requester                    rd,
    output logic                             o_done,
    output logic                             o_out_valid,
    output logic signed [img_pkg::OUT_W-1:0] o_out_data
);
    import img_pkg::*;

    logic       active;         // issuing one read per cycle
    logic [1:0] tile;           // 0 (x0,y0) 1 (x0+1,y0) 2 (x0,y0+1) 3 (x0+1,y0+1)
    logic [4:0] chan;
    logic       last_rd;
    logic [1:0] last_flight;    // final read moving through memory and output stage
    logic [3:0] col_w;
    logic [3:0] row_w;

    assign last_rd = active && (tile == 2'd3) && (chan == last_channel(i_depth));

    // one bit wider so an overrun would show
    assign col_w = {1'b0, i_origin_x} + {3'b000, tile[0]};
    assign row_w = {1'b0, i_origin_y} + {3'b000, tile[1]};

    // --------------------
    // read request
    assign rd.rd_en = active;

    always_comb begin
        rd.rd_addr.pix.bank  = chan[1:0];
        rd.rd_addr.pix.ch_hi = chan[4:2];
        rd.rd_addr.pix.row   = row_w[2:0];
        rd.rd_addr.pix.col   = col_w[2:0];
    end

    // tile steps every read, channel after the fourth tile
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            active      <= 1'b0;
            tile        <= 2'd0;
            chan        <= 5'd0;
            last_flight <= 2'b00;
            o_out_valid <= 1'b0;
        end else begin
            if (i_start) begin
                active <= 1'b1;
                tile   <= 2'd0;
                chan   <= 5'd0;
            end else if (active) begin
                tile <= tile + 2'd1;
                if (tile == 2'd3) begin
                    chan <= chan + 5'd1;
                end
                if (last_rd) begin
                    active <= 1'b0;
                end
            end
            last_flight <= {last_flight[0], last_rd};
            o_out_valid <= rd.rd_valid;
        end
    end

    // --------------------
    // output stage
    always_ff @(posedge i_clk) begin
        if (rd.rd_valid) begin
            o_out_data <= signed'(OUT_W'(rd.rd_data));   // zero-extended pixel
        end
    end

    assign o_done = last_flight[1];     // lines up with the last o_out_valid

    // origin clamp upstream keeps the window inside the image
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        rd.rd_en |-> (col_w <= 4'd7) && (row_w <= 4'd7));

endmodule

// File: hw/img_core_top.sv
module img_core_top #(
    parameter int BANK_AW = img_pkg::BANK_AW
) (
    input  logic                             i_clk,
    input  logic                             i_rst_n,
    input  logic                             i_op_valid,
    input  logic [3:0]                       i_op_mode,
    input  logic                             i_in_valid,
    input  logic [7:0]                       i_in_data,
    output logic                             o_op_ready,
    output logic                             o_in_ready,
    output logic                             o_out_valid,
    output logic signed [img_pkg::OUT_W-1:0] o_out_data
);
    import img_pkg::*;

    // write path
    logic       wr_en;
    pix_addr_u  wr_addr;
    logic [7:0] wr_data;

    // display control
    logic       disp_start;
    logic       disp_done;
    logic [2:0] origin_x;
    logic [2:0] origin_y;
    depth_e     depth;

    buf_read_if rd_bus ();

    op_control op_control_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_op_valid   (i_op_valid),
        .i_op_mode    (i_op_mode),
        .i_in_valid   (i_in_valid),
        .i_in_data    (i_in_data),
        .i_disp_done  (disp_done),
        .o_op_ready   (o_op_ready),
        .o_in_ready   (o_in_ready),
        .o_wr_en      (wr_en),
        .o_wr_addr    (wr_addr),
        .o_wr_data    (wr_data),
        .o_disp_start (disp_start),
        .o_origin_x   (origin_x),
        .o_origin_y   (origin_y),
        .o_depth      (depth)
    );

    display_streamer display_streamer_i (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_start     (disp_start),
        .i_origin_x  (origin_x),
        .i_origin_y  (origin_y),
        .i_depth     (depth),
        .rd          (rd_bus.requester),
        .o_done      (disp_done),
        .o_out_valid (o_out_valid),
        .o_out_data  (o_out_data)
    );

    image_buffer #(
        .BANK_AW (BANK_AW)
    ) image_buffer_i (
        .i_clk     (i_clk),
        .i_wr_en   (wr_en),
        .i_wr_addr (wr_addr),
        .i_wr_data (wr_data),
        .rd        (rd_bus.memory)
    );

endmodule

// File: tests/tb_img_core.sv
module tb_img_core;
    timeunit 1ns;
    timeprecision 100ps;
    import img_pkg::*;

    localparam logic [31:0] LFSR_TAPS = 32'h80200003;

    logic                    i_clk;
    logic                    i_rst_n;
    logic                    i_op_valid;
    logic [3:0]              i_op_mode;
    logic                    i_in_valid;
    logic [7:0]              i_in_data;
    logic                    o_op_ready;
    logic                    o_in_ready;
    logic                    o_out_valid;
    logic signed [OUT_W-1:0] o_out_data;

    logic [7:0]  image [IMG_PIX];   // model copy, channel-major raster
    logic [31:0] lfsr;
    int          cycle_cnt = 0;
    int          cycle_limit = 100;
    int          case_mode [$];
    int          case_arg [$];      // seed for load, repeat count otherwise
    int          case_x [$];
    int          case_y [$];
    int          case_d [$];

    img_core_top img_core_top_i (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_op_valid  (i_op_valid),
        .i_op_mode   (i_op_mode),
        .i_in_valid  (i_in_valid),
        .i_in_data   (i_in_data),
        .o_op_ready  (o_op_ready),
        .o_in_ready  (o_in_ready),
        .o_out_valid (o_out_valid),
        .o_out_data  (o_out_data)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout, the run did not finish within %0d cycles", cycle_limit);
            stop_with_failure();
        end
    end

    // --------------------
    // helpers
    task automatic stop_with_failure();
        $display("Test FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_eq(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error at %0d ns: %s expected %0h, actual %0h",
                     $time, name, expected, actual);
            stop_with_failure();
        end
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [7:0] v);
        v = 8'h00;
        for (int k = 0; k < n; k++) begin
            v = {v[6:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic next_cycle();
        @(posedge i_clk);
        #2;     // drive point, outputs settled
    endtask

    // opcode names as listed in the cases file
    function automatic int decode_op(input string name);
        if (name == "load")    return 0;
        if (name == "org_r")   return 1;
        if (name == "org_l")   return 2;
        if (name == "org_u")   return 3;
        if (name == "org_d")   return 4;
        if (name == "scale_d") return 5;
        if (name == "scale_u") return 6;
        if (name == "display") return 7;
        if (name == "undef")   return 16;   // raw opcode taken from arg
        return -1;
    endfunction

    task automatic read_cases();
        int          fd;
        int          n;
        int          mode;
        int          rep;
        int          x;
        int          y;
        int          d;
        string       line;
        string       cmd;
        logic [31:0] arg;
        fd = $fopen("tests/img_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open tests/img_cases.txt");
            stop_with_failure();
        end
        cycle_limit = 20;
        while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%s %h %d %d %d", cmd, arg, x, y, d);
            if (n <= 0 || line.getc(0) == "#") continue;
            mode = decode_op(cmd);
            if (n != 5 || mode < 0 || !(d inside {8, 16, 32})) begin
                $display("bad line in cases file: %s", line);
                stop_with_failure();
            end
            rep = int'(arg);
            if (mode == 16) begin
                mode = int'(arg[3:0]);
                rep = 1;
            end
            cycle_limit += (mode == 0) ? 3000 : 200 * rep;
            case_mode.push_back(mode);
            case_arg.push_back(rep);
            case_x.push_back(x);
            case_y.push_back(y);
            case_d.push_back(d);
        end
        $fclose(fd);
    endtask

    // --------------------
    // op players
    task automatic wait_ready(output int latency);
        latency = 0;
        check_eq("o_out_valid", 32'(o_out_valid), 0);
        while (o_op_ready !== 1'b1) begin
            next_cycle();
            latency++;
            check_eq("o_out_valid", 32'(o_out_valid), 0);
        end
        next_cycle();
        check_eq("o_op_ready", 32'(o_op_ready), 0);     // single cycle pulse
    endtask

    // called in the idle cycle right after a ready pulse
    task automatic issue_op(input int mode);
        i_op_valid = 1'b1;
        i_op_mode  = 4'(mode);
        next_cycle();
        i_op_valid = 1'b0;
    endtask

    task automatic run_adjust(input int mode);
        int lat;
        issue_op(mode);
        wait_ready(lat);
        check_eq("o_op_ready latency", lat, 1);     // two cycles after acceptance
    endtask

    task automatic run_load(input int seed);
        int         lat;
        logic [7:0] gap;
        logic [7:0] pix;
        lfsr = seed;
        issue_op(0);
        check_eq("o_in_ready", 32'(o_in_ready), 1);
        for (int p = 0; p < IMG_PIX; p++) begin
            if (p % 4 == 0) begin
                take_bits(1, gap);
                if (gap[0]) begin
                    i_in_valid = 1'b0;
                    next_cycle();
                end
            end
            take_bits(8, pix);
            image[p]   = pix;
            i_in_valid = 1'b1;
            i_in_data  = pix;
            next_cycle();
            check_eq("o_in_ready", 32'(o_in_ready), 32'(p < IMG_PIX - 1));
        end
        i_in_valid = 1'b0;
        wait_ready(lat);
        check_eq("o_op_ready latency", lat, 0);
    endtask

    task automatic run_display(input int x, input int y, input int d);
        int          n;
        int          t;
        int          lat;
        logic [31:0] expected;
        issue_op(7);
        n = 0;
        while (n < 4 * d) begin
            if (o_out_valid === 1'b1) begin
                t = n % 4;  // (x0,y0) (x0+1,y0) (x0,y0+1) (x0+1,y0+1)
                expected = 32'(image[(n / 4) * 64 + (y + t / 2) * 8 + x + t % 2]);
                check_eq("o_out_data", 32'(o_out_data), expected);
                n++;
            end
            next_cycle();
        end
        wait_ready(lat);
        check_eq("o_op_ready latency", lat, 0);
    endtask

    // --------------------
    // main sequence
    initial begin
        int lat;
        int done_cases;
        i_rst_n    = 1'b0;
        i_op_valid = 1'b0;
        i_op_mode  = 4'd0;
        i_in_valid = 1'b0;
        i_in_data  = 8'd0;
        done_cases = 0;
        read_cases();
        repeat (4) @(posedge i_clk);
        #2;
        i_rst_n = 1'b1;
        check_eq("o_op_ready", 32'(o_op_ready), 0);
        check_eq("o_in_ready", 32'(o_in_ready), 0);
        check_eq("o_out_valid", 32'(o_out_valid), 0);
        wait_ready(lat);
        foreach (case_mode[i]) begin
            if (case_mode[i] == 0) begin
                run_load(case_arg[i]);
            end else if (case_mode[i] == 7) begin
                run_display(case_x[i], case_y[i], case_d[i]);
            end else begin
                for (int r = 0; r < case_arg[i]; r++) begin
                    run_adjust(case_mode[i]);
                end
            end
            check_eq("origin_x", 32'(img_core_top_i.origin_x), case_x[i]);
            check_eq("origin_y", 32'(img_core_top_i.origin_y), case_y[i]);
            check_eq("depth", 32'(img_core_top_i.depth), case_d[i] / 16); // 8 16 32 as 0 1 2
            done_cases++;
        end
        if (done_cases == 0) begin
            $display("no cases were read from tests/img_cases.txt");
            stop_with_failure();
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

// File: tests/img_cases.txt
# command  arg       origin_x origin_y depth (expected after the step)
# arg is the LFSR seed for load, the raw opcode for undef, else a repeat count
load       75b1df64  0 0 32
undef      b         0 0 32
display    1         0 0 32
org_r      3         3 0 32
org_d      2         3 2 32
display    1         3 2 32
org_r      5         6 2 32
org_d      6         6 6 32
display    1         6 6 32
org_l      8         0 6 32
org_u      2         0 4 32
display    1         0 4 32
org_u      9         0 0 32
undef      f         0 0 32
scale_d    2         0 0 8
scale_d    1         0 0 8
display    1         0 0 8
scale_u    1         0 0 16
org_r      1         1 0 16
org_d      7         1 6 16
display    1         1 6 16

// File: sources.f
hw/img_pkg.sv
hw/buf_read_if.sv
hw/sram_bank.sv
hw/image_buffer.sv
hw/op_control.sv
hw/display_streamer.sv
hw/img_core_top.sv
tests/tb_img_core.sv

// File: run_sim.sh
#!/bin/sh
# build and run the image core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_img_core -Mdir obj_dir -o sim_img_core -f sources.f

./obj_dir/sim_img_core > sim.log 2>&1 || true
cat sim.log

if grep -q "Test FAILED" sim.log; then
    exit 1
fi
